// File: src/qr_pkg.sv
`default_nettype none

package qr_pkg;

    localparam int img_dim = 64;
    localparam int sym_dim = 25;
    localparam int def_max_len = 32;

    // format bits: symbol row 8, cols 2..4, msb first
    localparam int fmt_row = 8;
    localparam int fmt_col0 = 2;
    localparam logic [2:0] fmt_xor = 3'b101;

    typedef logic [11:0] addr_t; // {row, col}

    typedef struct packed {
        logic [4:0] row;
        logic [4:0] col;
    } coord_t;

    typedef struct packed {
        logic [5:0] row; // origin in the image
        logic [5:0] col;
        logic [2:0] mask_id;
    } sym_info_t;

    // standard QR data mask conditions, i = row, j = col
    function automatic logic mask_hit(input logic [2:0] mask_id, input logic [4:0] row,
                                      input logic [4:0] col);
        int i;
        int j;
        int p;
        logic hit;
        i = int'(row);
        j = int'(col);
        p = i * j;
        case (mask_id)
            3'd0: hit = ((i + j) % 2) == 0;
            3'd1: hit = (i % 2) == 0;
            3'd2: hit = (j % 3) == 0;
            3'd3: hit = ((i + j) % 3) == 0;
            3'd4: hit = ((i / 2 + j / 3) % 2) == 0;
            3'd5: hit = ((p % 2) + (p % 3)) == 0;
            3'd6: hit = (((p % 2) + (p % 3)) % 2) == 0;
            default: hit = ((((i + j) % 2) + (p % 3)) % 2) == 0;
        endcase
        return hit;
    endfunction

endpackage

`default_nettype wire

// File: src/symbol_locator.sv
`timescale 1ns/1ps
`default_nettype none

module symbol_locator import qr_pkg::*; (
    input  logic      clk,
    input  logic      srstn,
    input  logic      go_locate,
    input  logic      sram_rdata,
    output addr_t     raddr,
    output sym_info_t sym_info,
    output logic      located
);

    typedef enum logic [1:0] {st_idle, st_scan, st_fmt} loc_state_t;

    loc_state_t state;
    addr_t      scan_addr;
    addr_t      scan_prev;
    addr_t      fmt_addr;
    logic       scan_live;   // a scan read is in flight
    logic [1:0] fmt_cnt;
    logic [1:0] fmt_bits;
    logic       hit;

    assign scan_prev = scan_addr - 12'd1;
    assign hit = (state == st_scan) && scan_live && sram_rdata;
    assign fmt_addr = {sym_info.row + 6'(fmt_row), sym_info.col + 6'(fmt_col0) + 6'(fmt_cnt)};
    assign raddr = (state == st_fmt) ? fmt_addr : scan_addr;

    always_ff @(posedge clk) begin
        if (!srstn) begin
            state <= st_idle;
            scan_addr <= '0;
            scan_live <= 1'b0;
            fmt_cnt <= '0;
            located <= 1'b0;
        end else begin
            located <= 1'b0;
            case (state)
                st_idle: begin
                    if (go_locate) begin
                        state <= st_scan;
                        scan_addr <= '0;
                        scan_live <= 1'b0;
                    end
                end
                st_scan: begin
                    scan_addr <= scan_addr + 12'd1;
                    scan_live <= 1'b1;
                    if (hit) begin
                        state <= st_fmt;
                        fmt_cnt <= '0;
                    end
                end
                default: begin
                    if (fmt_cnt == 2'd3) begin
                        located <= 1'b1;
                        state <= st_idle;
                    end else begin
                        fmt_cnt <= fmt_cnt + 2'd1;
                    end
                end
            endcase
        end
    end

    // origin and format bits
    always_ff @(posedge clk) begin
        if (hit) begin
            sym_info.row <= scan_prev[11:6]; // hit belongs to the previous address
            sym_info.col <= scan_prev[5:0];
        end
        if (state == st_fmt && fmt_cnt != 2'd0) begin
            fmt_bits <= {fmt_bits[0], sram_rdata};
        end
        if (state == st_fmt && fmt_cnt == 2'd3) begin
            sym_info.mask_id <= {fmt_bits, sram_rdata} ^ fmt_xor;
        end
    end

    assert property (@(posedge clk) disable iff (!srstn)
        located |-> (int'(sym_info.row) <= img_dim - sym_dim) &&
                    (int'(sym_info.col) <= img_dim - sym_dim));

endmodule

`default_nettype wire

// File: src/module_walker.sv
`timescale 1ns/1ps
`default_nettype none

module module_walker import qr_pkg::*; (
    input  logic      clk,
    input  logic      srstn,
    input  logic      go_walk,
    input  sym_info_t sym_info,
    input  logic      done,
    output addr_t     raddr,
    output logic      rd_valid,
    output coord_t    rd_loc
);

    logic       active;
    logic [4:0] row;
    logic [4:0] rc;      // right column of the current pair
    logic       left;    // on the left column of the pair
    logic       up;      // moving toward row 0
    logic [4:0] col_now;
    logic [4:0] nrc;
    logic [5:0] step;    // {found, row} inside the current pair
    logic [5:0] first;   // entry row of the next pair
    logic [sym_dim-1:0] beyond;

    // finders with format areas, timing lines, alignment block
    function automatic logic is_func(input logic [4:0] r, input logic [4:0] c);
        return (r < 5'd9 && c < 5'd9) || (r < 5'd9 && c > 5'd16) ||
               (r > 5'd16 && c < 5'd9) || r == 5'd6 || c == 5'd6 ||
               (r >= 5'd16 && r <= 5'd20 && c >= 5'd16 && c <= 5'd20);
    endfunction

    function automatic logic [sym_dim-1:0] row_mask(input logic [4:0] c);
        logic [sym_dim-1:0] m;
        for (int r = 0; r < sym_dim; r++) begin
            m[r] = !is_func(5'(r), c) || !is_func(5'(r), c - 5'd1);
        end
        return m;
    endfunction

    // first set row in walking order
    function automatic logic [5:0] pick_row(input logic [sym_dim-1:0] m, input logic up_dir);
        logic [5:0] res;
        res = '0;
        for (int r = 0; r < sym_dim; r++) begin
            if (up_dir) begin
                if (m[r]) res = {1'b1, 5'(r)};
            end else if (m[sym_dim-1-r]) begin
                res = {1'b1, 5'(sym_dim - 1 - r)};
            end
        end
        return res;
    endfunction

    always_comb begin
        for (int r = 0; r < sym_dim; r++) begin
            beyond[r] = up ? (5'(r) < row) : (5'(r) > row);
        end
        nrc = (rc == 5'd8) ? 5'd5 : rc - 5'd2; // hop over the timing column
        step = pick_row(row_mask(rc) & beyond, up);
        first = pick_row(row_mask(nrc), !up);
    end

    assign col_now = left ? rc - 5'd1 : rc;
    assign rd_valid = active;
    assign rd_loc = '{row: row, col: col_now};
    assign raddr = {sym_info.row + 6'(row), sym_info.col + 6'(col_now)};

    always_ff @(posedge clk) begin
        if (!srstn) begin
            active <= 1'b0;
            row <= '0;
            rc <= '0;
            left <= 1'b0;
            up <= 1'b0;
        end else if (go_walk) begin
            active <= 1'b1;
            row <= 5'd24;
            rc <= 5'd24;
            left <= 1'b0;
            up <= 1'b1;
        end else if (active) begin
            if (done) begin
                active <= 1'b0;
            end else if (!left && !is_func(row, rc - 5'd1)) begin
                left <= 1'b1;
            end else if (step[5]) begin
                row <= step[4:0];
                left <= is_func(step[4:0], rc);
            end else if (rc == 5'd1) begin
                active <= 1'b0; // data region exhausted
            end else begin
                rc <= nrc;
                up <= !up;
                row <= first[4:0];
                left <= is_func(first[4:0], nrc);
            end
        end
    end

endmodule

`default_nettype wire

// File: src/mask_remover.sv
`timescale 1ns/1ps
`default_nettype none

module mask_remover import qr_pkg::*; (
    input  logic       clk,
    input  logic       srstn,
    input  logic       rd_valid,
    input  coord_t     rd_loc,
    input  logic [2:0] mask_id,
    input  logic       sram_rdata,
    output logic       data_valid,
    output logic       data_bit
);

    logic   vld_q;
    coord_t loc_q;  // lines up with the returning bit

    always_ff @(posedge clk) begin
        if (!srstn) begin
            vld_q <= 1'b0;
            data_valid <= 1'b0;
        end else begin
            vld_q <= rd_valid;
            data_valid <= vld_q;
        end
    end

    always_ff @(posedge clk) begin
        loc_q <= rd_loc;
        data_bit <= sram_rdata ^ mask_hit(mask_id, loc_q.row, loc_q.col);
    end

endmodule

`default_nettype wire

// File: src/byte_assembler.sv
`timescale 1ns/1ps
`default_nettype none

module byte_assembler import qr_pkg::*; #(
    parameter int max_len = def_max_len
) (
    input  logic       clk,
    input  logic       srstn,
    input  logic       go_walk,
    input  logic       data_valid,
    input  logic       data_bit,
    output logic       byte_valid,
    output logic [7:0] byte_data,
    output logic       done
);

    logic       busy;
    logic [3:0] hdr_cnt;   // mode and length bits seen
    logic [2:0] bit_cnt;
    logic [7:0] byte_cnt;
    logic [7:0] len;
    logic [7:0] shreg;
    logic [7:0] next_sh;
    logic       take;
    logic       in_hdr;

    assign next_sh = {shreg[6:0], data_bit};
    assign take = busy && data_valid;
    assign in_hdr = hdr_cnt != 4'd12;

    always_ff @(posedge clk) begin
        if (!srstn) begin
            busy <= 1'b0;
            hdr_cnt <= '0;
            bit_cnt <= '0;
            byte_cnt <= '0;
            byte_valid <= 1'b0;
            done <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            done <= byte_valid && (byte_cnt == len); // one cycle after last byte
            if (go_walk) begin
                busy <= 1'b1;
                hdr_cnt <= '0;
                bit_cnt <= '0;
                byte_cnt <= '0;
            end else if (take && in_hdr) begin
                hdr_cnt <= hdr_cnt + 4'd1;
                if (hdr_cnt == 4'd11 && next_sh == 8'd0) begin
                    busy <= 1'b0;
                    done <= 1'b1;  // empty payload
                end
            end else if (take) begin
                bit_cnt <= bit_cnt + 3'd1;
                if (bit_cnt == 3'd7) begin
                    byte_valid <= 1'b1;
                    byte_cnt <= byte_cnt + 8'd1;
                    if (byte_cnt + 8'd1 == len) busy <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) shreg <= next_sh;
        if (take && hdr_cnt == 4'd11) len <= next_sh;
        if (take && !in_hdr && bit_cnt == 3'd7) byte_data <= next_sh;
    end

    assert property (@(posedge clk) disable iff (!srstn)
        take && hdr_cnt == 4'd11 |=> int'(len) <= max_len);

endmodule

`default_nettype wire

// File: src/qr_decode.sv
`timescale 1ns/1ps
`default_nettype none

module qr_decode import qr_pkg::*; #(
    parameter int max_len = def_max_len
) (
    input  logic       clk,
    input  logic       srstn,
    input  logic       qr_decode_start,
    input  logic       sram_rdata,
    output addr_t      sram_raddr,
    output logic       decode_valid,
    output logic [7:0] decode_jis8_code,
    output logic       qr_decode_finish
);

    typedef enum logic [1:0] {ph_idle, ph_locate, ph_walk, ph_finished} phase_t;

    phase_t    phase;
    logic      go_locate;
    logic      go_walk;
    logic      located;
    logic      done;
    sym_info_t sym_info;
    addr_t     loc_raddr;
    addr_t     walk_raddr;
    logic      rd_valid;
    coord_t    rd_loc;
    logic      data_valid;
    logic      data_bit;

    assign go_locate = qr_decode_start && (phase == ph_idle || phase == ph_finished);
    assign go_walk = located && (phase == ph_locate);
    assign sram_raddr = (phase == ph_locate) ? loc_raddr : walk_raddr;
    assign qr_decode_finish = (phase == ph_finished) || done; // done is the rising edge

    always_ff @(posedge clk) begin
        if (!srstn) begin
            phase <= ph_idle;
        end else if (go_locate) begin
            phase <= ph_locate;
        end else if (go_walk) begin
            phase <= ph_walk;
        end else if (done && phase == ph_walk) begin
            phase <= ph_finished;
        end
    end

    symbol_locator symbol_locator_inst (
        .clk(clk), .srstn(srstn), .go_locate(go_locate), .sram_rdata(sram_rdata),
        .raddr(loc_raddr), .sym_info(sym_info), .located(located)
    );

    module_walker module_walker_inst (
        .clk(clk), .srstn(srstn), .go_walk(go_walk), .sym_info(sym_info), .done(done),
        .raddr(walk_raddr), .rd_valid(rd_valid), .rd_loc(rd_loc)
    );

    mask_remover mask_remover_inst (
        .clk(clk), .srstn(srstn), .rd_valid(rd_valid), .rd_loc(rd_loc),
        .mask_id(sym_info.mask_id), .sram_rdata(sram_rdata),
        .data_valid(data_valid), .data_bit(data_bit)
    );

    byte_assembler #(.max_len(max_len)) byte_assembler_inst (
        .clk(clk), .srstn(srstn), .go_walk(go_walk), .data_valid(data_valid),
        .data_bit(data_bit), .byte_valid(decode_valid), .byte_data(decode_jis8_code),
        .done(done)
    );

    // no restart while a decode is running
    assert property (@(posedge clk) disable iff (!srstn)
        qr_decode_start |-> !(phase inside {ph_locate, ph_walk}));

endmodule

`default_nettype wire

// File: verif/qr_image_model.svh
// builds one upright version 2 symbol into image_mem
// bit stream is mode 0100, length, payload bytes, then zero padding

// finder and format areas, timing lines, alignment block
function automatic bit is_function_module(input int r, input int c);
    return (r < 9 && c < 9) || (r < 9 && c > 16) || (r > 16 && c < 9) ||
           r == 6 || c == 6 || (r >= 16 && r <= 20 && c >= 16 && c <= 20);
endfunction

// standard data mask conditions, i = row, j = col
function automatic bit mask_flips(input int m, input int i, input int j);
    int ij;
    ij = i * j;
    case (m)
        0: return ((i + j) % 2) == 0;
        1: return (i % 2) == 0;
        2: return (j % 3) == 0;
        3: return ((i + j) % 3) == 0;
        4: return ((i / 2 + j / 3) % 2) == 0;
        5: return ((ij % 2) + (ij % 3)) == 0;
        6: return (((ij % 2) + (ij % 3)) % 2) == 0;
        default: return ((((i + j) % 2) + (ij % 3)) % 2) == 0;
    endcase
endfunction

task automatic put_module(input int org_row, input int org_col, input int r, input int c,
                          input bit v);
    image_mem[(org_row + r) * 64 + org_col + c] = v;
endtask

task automatic build_symbol(input int org_row, input int org_col, input int mask_id);
    bit         stream[$];
    logic [3:0] mode;
    logic [7:0] len_bits;
    logic [2:0] fmt;
    int         k;
    int         r;
    int         rc;
    bit         up;
    bit         b;
    mode = 4'b0100;
    len_bits = 8'(exp_len);
    fmt = 3'(mask_id) ^ 3'b101;
    for (int a = 0; a < 4096; a++) image_mem[a] = 1'b0;
    for (r = 0; r < 7; r++) begin
        for (int c = 0; c < 7; c++) begin
            put_module(org_row, org_col, r, c, r == 0 || r == 6 || c == 0 || c == 6 ||
                       (r >= 2 && r <= 4 && c >= 2 && c <= 4));
        end
    end
    for (int f = 0; f < 3; f++) put_module(org_row, org_col, 8, 2 + f, fmt[2 - f]); // msb first
    for (int n = 3; n >= 0; n--) stream.push_back(mode[n]);
    for (int n = 7; n >= 0; n--) stream.push_back(len_bits[n]);
    for (int p = 0; p < exp_len; p++) begin
        for (int n = 7; n >= 0; n--) stream.push_back(exp_bytes[p][n]);
    end
    // zigzag from the bottom right, column pairs leftward
    k = 0;
    up = 1'b1;
    rc = 24;
    while (rc >= 1) begin
        for (int s = 0; s < 25; s++) begin
            r = up ? 24 - s : s;
            for (int d = 0; d < 2; d++) begin
                if (!is_function_module(r, rc - d)) begin
                    b = (k < stream.size()) ? stream[k] : 1'b0;
                    k++;
                    put_module(org_row, org_col, r, rc - d, b ^ mask_flips(mask_id, r, rc - d));
                end
            end
        end
        up = !up;
        rc = (rc == 8) ? 5 : rc - 2; // timing column is skipped
    end
endtask

// File: verif/tb_qr_decode.sv
`timescale 1ns/1ps
`default_nettype none

module tb_qr_decode;

    localparam int max_len = 32;
    localparam int finish_timeout = 20000;

    logic        clk;
    logic        srstn;
    logic        qr_decode_start;
    logic        sram_rdata;
    logic [11:0] sram_raddr;
    logic        decode_valid;
    logic [7:0]  decode_jis8_code;
    logic        qr_decode_finish;

    logic        image_mem [0:4095];
    logic [7:0]  exp_bytes [0:max_len-1];
    int          exp_len;
    int          got_cnt;
    int          seed = 32'h6f065110;
    bit          running;       // a decode is expected to be in progress
    bit          decoded_once;
    string       test_name;
    logic [11:0] raddr_q;

    `include "qr_image_model.svh"

    qr_decode #(.max_len(max_len)) qr_decode_inst (
        .clk(clk), .srstn(srstn), .qr_decode_start(qr_decode_start),
        .sram_rdata(sram_rdata), .sram_raddr(sram_raddr), .decode_valid(decode_valid),
        .decode_jis8_code(decode_jis8_code), .qr_decode_finish(qr_decode_finish)
    );

    always #5 clk = ~clk;

    // sram with one cycle read latency
    always @(posedge clk) begin
        raddr_q = sram_raddr;
        #1 sram_rdata = image_mem[raddr_q];
    end

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1);
    endtask

    function automatic int random_coord();
        return $unsigned($random(seed)) % 40; // keeps the symbol inside the image
    endfunction

    task automatic fill_random_payload();
        for (int k = 0; k < exp_len; k++) begin
            exp_bytes[k] = 8'($random(seed));
        end
    endtask

    task automatic wait_finish();
        int  n;
        bit  seen;
        n = 0;
        seen = 1'b0;
        while (!seen && n < finish_timeout) begin
            @(posedge clk);
            seen = qr_decode_finish;
            n++;
        end
        if (!seen) stop_with_failure($sformatf("timeout waiting for finish in %s", test_name));
    endtask

    task automatic decode_symbol(input string name, input int org_row, input int org_col,
                                 input int mask_id);
        test_name = name;
        build_symbol(org_row, org_col, mask_id);
        @(posedge clk);
        #1 qr_decode_start = 1'b1;
        decoded_once = 1'b1;
        @(posedge clk);
        #1 qr_decode_start = 1'b0;
        running = 1'b1;
        wait_finish();
        #1 running = 1'b0;
        repeat (20) @(posedge clk); // late strobes land in the checker
    endtask

    // checking
    always @(posedge clk) begin
        if (srstn) begin
            if (!decoded_once) begin
                assert (!decode_valid && !qr_decode_finish)
                    else stop_with_failure("strobe or finish high before the first start");
            end
            if (qr_decode_start) got_cnt <= 0;
            if (decode_valid) begin
                assert (running)
                    else stop_with_failure($sformatf("byte strobe after finish in %s", test_name));
                assert (got_cnt < exp_len)
                    else stop_with_failure($sformatf("%s gave more bytes than its length",
                                                     test_name));
                assert (decode_jis8_code == exp_bytes[got_cnt])
                    else stop_with_failure($sformatf("error %s byte %0d expected 0x%02h actual 0x%02h",
                                                     test_name, got_cnt, exp_bytes[got_cnt],
                                                     decode_jis8_code));
                got_cnt <= got_cnt + 1;
            end
            if (running && qr_decode_finish) begin
                assert (got_cnt == exp_len)
                    else stop_with_failure($sformatf("error %s byte count expected %0d actual %0d",
                                                     test_name, exp_len, got_cnt));
            end
        end
    end

    initial begin
        int r;
        int c;
        clk = 1'b0;
        srstn = 1'b0;
        qr_decode_start = 1'b0;
        sram_rdata = 1'b0;
        running = 1'b0;
        decoded_once = 1'b0;
        exp_len = 0;
        test_name = "reset";
        repeat (8) @(posedge clk);
        #1 srstn = 1'b1;

        test_name = "idle_after_reset";
        repeat (20) @(posedge clk);

        exp_len = 5;
        exp_bytes[0] = 8'h48;
        exp_bytes[1] = 8'h65;
        exp_bytes[2] = 8'h6c;
        exp_bytes[3] = 8'h6c;
        exp_bytes[4] = 8'h6f;
        decode_symbol("origin_zero_mask0", 0, 0, 0);

        for (int m = 0; m < 8; m++) begin
            exp_len = 1 + $unsigned($random(seed)) % 16;
            fill_random_payload();
            r = random_coord();
            c = random_coord();
            decode_symbol($sformatf("mask_%0d", m), r, c, m);
        end

        exp_len = 1;
        fill_random_payload();
        r = random_coord();
        c = random_coord();
        decode_symbol("length_one", r, c, $unsigned($random(seed)) % 8);

        exp_len = max_len;
        fill_random_payload();
        r = random_coord();
        c = random_coord();
        decode_symbol("length_max", r, c, $unsigned($random(seed)) % 8);

        // fresh image after a finished decode
        exp_len = 7;
        fill_random_payload();
        decode_symbol("restart_new_image", 39, 17, 5);

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+verif
src/qr_pkg.sv
src/symbol_locator.sv
src/module_walker.sv
src/mask_remover.sv
src/byte_assembler.sv
src/qr_decode.sv
verif/tb_qr_decode.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        ?= tb_qr_decode
FILELIST   ?= all.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= Test OK
COMMON     ?= --timing --assert --timescale 1ns/1ps --top-module $(TOP)
LINT_FLAGS ?= --lint-only
SIM_FLAGS  ?= --binary -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(COMMON) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) $(COMMON) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
